//--- hw/mips_mem_pkg.sv
package mips_mem_pkg;

    // Datapath widths
    localparam int DATA_W    = 32;                  // Register and memory word
    localparam int PC_W      = 32;                  // Program counter
    localparam int REG_W     = 5;                   // Register file index

    // Data memory geometry
    localparam int BYTE_W    = 8;                   // One memory cell and the debug data
    localparam int HALF_W    = 2 * BYTE_W;          // Halfword access width
    localparam int DM_ADDR_W = 7;                   // Byte address into data memory
    localparam int DM_BYTES  = 1 << DM_ADDR_W;      // 128 bytes

    // Load/store access size decoded from the opcode in EX
    // Decode never produces code 2'b11 and the memory treats it as no access
    typedef enum logic [1:0] {
        ACC_WORD = 2'b00,                           // lw / sw
        ACC_HALF = 2'b01,                           // lhu / sh
        ACC_BYTE = 2'b10                            // lbu / sb
    } access_size_t;

endpackage

//--- hw/mem_wb_if.sv
`timescale 1ns/100ps

interface mem_wb_if import mips_mem_pkg::*; ();

    logic [REG_W-1:0]  selected_reg;                // Destination register rd or rt
    logic              reg_write;                   // WB writes the register file
    logic              mem_to_reg;                  // WB takes mem_data, not alu_result
    logic              r31_ctrl;                    // Link write to r31 for jal
    logic [PC_W-1:0]   pc;                          // Return address for link
    logic [DATA_W-1:0] alu_result;
    logic [DATA_W-1:0] mem_data;                    // Zero-extended load result
    logic              hlt;                         // Halt travels down to WB

    // MEM stage side
    modport stage (
        output selected_reg, reg_write, mem_to_reg, r31_ctrl,
        output pc, alu_result, mem_data, hlt
    );

    // Pipeline register side
    modport wb (
        input  selected_reg, reg_write, mem_to_reg, r31_ctrl,
        input  pc, alu_result, mem_data, hlt
    );

endinterface

//--- hw/data_memory.sv
`timescale 1ns/100ps

module data_memory import mips_mem_pkg::*; (
    input  logic                 i_clock,
    input  logic                 i_mem_write,       // Store this cycle
    input  logic                 i_mem_read,        // Load this cycle
    input  access_size_t         i_size,
    input  logic [DM_ADDR_W-1:0] i_address,         // Low bits of the ALU result
    input  logic [DATA_W-1:0]    i_write_data,      // Register rt value
    output logic [DATA_W-1:0]    o_read_data,
    input  logic                 i_dbg_read_en,     // Debug unit
    input  logic [DM_ADDR_W-1:0] i_dbg_address,     // Debug unit
    output logic [BYTE_W-1:0]    o_dbg_byte         // Debug unit
);

    logic [BYTE_W-1:0] mem [DM_BYTES];              // Little-endian byte array

    // Word rows drop address bits 1:0 and halfword rows drop bit 0
    logic [DM_ADDR_W-3:0] word_row;
    logic [DM_ADDR_W-2:0] half_row;

    logic [DATA_W-1:0] word_data;
    logic [HALF_W-1:0] half_data;
    logic [BYTE_W-1:0] byte_data;

    assign word_row = i_address[DM_ADDR_W-1:2];
    assign half_row = i_address[DM_ADDR_W-1:1];

    // Stores are written at the end of the cycle
    always_ff @(posedge i_clock) begin
        if (i_mem_write) begin
            case (i_size)
                ACC_WORD: begin
                    mem[{word_row, 2'd0}] <= i_write_data[BYTE_W-1:0];
                    mem[{word_row, 2'd1}] <= i_write_data[2*BYTE_W-1:BYTE_W];
                    mem[{word_row, 2'd2}] <= i_write_data[3*BYTE_W-1:2*BYTE_W];
                    mem[{word_row, 2'd3}] <= i_write_data[4*BYTE_W-1:3*BYTE_W];
                end
                ACC_HALF: begin
                    mem[{half_row, 1'b0}] <= i_write_data[BYTE_W-1:0];
                    mem[{half_row, 1'b1}] <= i_write_data[2*BYTE_W-1:BYTE_W];
                end
                ACC_BYTE: begin
                    mem[i_address] <= i_write_data[BYTE_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Aligned views of the current content
    assign word_data = {mem[{word_row, 2'd3}],
                        mem[{word_row, 2'd2}],
                        mem[{word_row, 2'd1}],
                        mem[{word_row, 2'd0}]};

    assign half_data = {mem[{half_row, 1'b1}],
                        mem[{half_row, 1'b0}]};

    assign byte_data = mem[i_address];

    // Loads read before the edge, so a same-cycle store is not visible yet
    always_comb begin
        o_read_data = '0;
        if (i_mem_read) begin
            case (i_size)
                ACC_WORD: o_read_data = word_data;
                ACC_HALF: o_read_data = {{(DATA_W-HALF_W){1'b0}}, half_data};
                ACC_BYTE: o_read_data = {{(DATA_W-BYTE_W){1'b0}}, byte_data};
                default:  o_read_data = '0;
            endcase
        end
    end

    // Debug byte port is independent of the pipeline access
    assign o_dbg_byte = i_dbg_read_en ? mem[i_dbg_address] : '0;

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/100ps

module mem_stage import mips_mem_pkg::*; (
    input  logic                 i_clock,
    input  logic                 i_mem_read,        // Load instruction
    input  logic                 i_mem_write,       // Store instruction
    input  access_size_t         i_size,
    input  logic                 i_branch,          // beq/bne in MEM
    input  logic                 i_zero,            // ALU zero flag
    input  logic [PC_W-1:0]      i_branch_addr,     // Target computed in EX
    input  logic [DATA_W-1:0]    i_alu_result,      // Memory address or R-type result
    input  logic [DATA_W-1:0]    i_write_data,      // Store data, rt from EX
    input  logic [REG_W-1:0]     i_selected_reg,
    input  logic                 i_reg_write,
    input  logic                 i_mem_to_reg,
    input  logic                 i_r31_ctrl,
    input  logic                 i_hlt,
    input  logic [PC_W-1:0]      i_pc,
    input  logic                 i_dbg_read_en,
    input  logic [DM_ADDR_W-1:0] i_dbg_address,
    output logic [BYTE_W-1:0]    o_dbg_byte,
    output logic                 o_branch_taken,    // Fetch PC mux select
    output logic [PC_W-1:0]      o_branch_addr,
    mem_wb_if.stage              mem_wb
);

    logic [DATA_W-1:0] load_data;

    data_memory u_data_memory (
        .i_clock       (i_clock),
        .i_mem_write   (i_mem_write),
        .i_mem_read    (i_mem_read),
        .i_size        (i_size),
        .i_address     (i_alu_result[DM_ADDR_W-1:0]),   // Upper address bits unused
        .i_write_data  (i_write_data),
        .o_read_data   (load_data),
        .i_dbg_read_en (i_dbg_read_en),
        .i_dbg_address (i_dbg_address),
        .o_dbg_byte    (o_dbg_byte)
    );

    // Branch resolution back to fetch
    assign o_branch_taken = i_branch & i_zero;
    assign o_branch_addr  = i_branch_addr;

    // Results and control for write-back
    assign mem_wb.mem_data     = load_data;     // Zero for non-loads
    assign mem_wb.alu_result   = i_alu_result;
    assign mem_wb.selected_reg = i_selected_reg;
    assign mem_wb.reg_write    = i_reg_write;
    assign mem_wb.mem_to_reg   = i_mem_to_reg;
    assign mem_wb.r31_ctrl     = i_r31_ctrl;
    assign mem_wb.pc           = i_pc;
    assign mem_wb.hlt          = i_hlt;

endmodule

//--- hw/mem_wb_register.sv
`timescale 1ns/100ps

module mem_wb_register import mips_mem_pkg::*; (
    input  logic              i_clock,
    input  logic              i_rst,
    mem_wb_if.wb              mem_wb,
    output logic [DATA_W-1:0] o_mem_data,
    output logic [DATA_W-1:0] o_alu_result,
    output logic [REG_W-1:0]  o_selected_reg,
    output logic              o_reg_write,
    output logic              o_mem_to_reg,
    output logic              o_r31_ctrl,
    output logic              o_hlt,
    output logic [PC_W-1:0]   o_pc
);

    logic              reg_write_q;
    logic              mem_to_reg_q;
    logic              hlt_q;
    logic [DATA_W-1:0] mem_data_q;
    logic [DATA_W-1:0] alu_result_q;
    logic [REG_W-1:0]  selected_reg_q;
    logic              r31_ctrl_q;
    logic [PC_W-1:0]   pc_q;

    // Control bits are cleared so WB does nothing right after reset
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
            hlt_q        <= 1'b0;
        end else begin
            reg_write_q  <= mem_wb.reg_write;
            mem_to_reg_q <= mem_wb.mem_to_reg;
            hlt_q        <= mem_wb.hlt;
        end
    end

    // Payload fields
    always_ff @(posedge i_clock) begin
        mem_data_q     <= mem_wb.mem_data;
        alu_result_q   <= mem_wb.alu_result;
        selected_reg_q <= mem_wb.selected_reg;
        r31_ctrl_q     <= mem_wb.r31_ctrl;  // Only acts together with reg_write
        pc_q           <= mem_wb.pc;
    end

    assign o_reg_write    = reg_write_q;
    assign o_mem_to_reg   = mem_to_reg_q;
    assign o_hlt          = hlt_q;
    assign o_mem_data     = mem_data_q;
    assign o_alu_result   = alu_result_q;
    assign o_selected_reg = selected_reg_q;
    assign o_r31_ctrl     = r31_ctrl_q;
    assign o_pc           = pc_q;

endmodule

//--- hw/debug_dm_reader.sv
`timescale 1ns/100ps

module debug_dm_reader import mips_mem_pkg::*; (
    input  logic                 i_clock,
    input  logic                 i_rst,
    // Wishbone classic slave
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    input  logic                 i_wb_we,
    input  logic [DM_ADDR_W-1:0] i_wb_adr,
    output logic [BYTE_W-1:0]    o_wb_dat,
    output logic                 o_wb_ack,
    // Data memory debug port
    output logic                 o_dbg_read_en,
    output logic [DM_ADDR_W-1:0] o_dbg_address,
    input  logic [BYTE_W-1:0]    i_dbg_byte
);

    logic              ack_q;
    logic [BYTE_W-1:0] dat_q;
    logic              new_req;             // First cycle of a bus cycle

    // Master holds stb until ack, so ack low marks a request not yet served
    assign new_req = i_wb_cyc & i_wb_stb & ~ack_q;

    // Writes never reach the memory
    assign o_dbg_read_en = new_req & ~i_wb_we;
    assign o_dbg_address = i_wb_adr;

    // Single-cycle ack
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= new_req;
        end
    end

    // Read byte captured alongside ack and zero on a write cycle
    always_ff @(posedge i_clock) begin
        if (new_req) begin
            dat_q <= i_dbg_byte;
        end
    end

    assign o_wb_ack = ack_q;
    assign o_wb_dat = dat_q;

endmodule

//--- hw/mem_subsystem_top.sv
`timescale 1ns/100ps

module mem_subsystem_top import mips_mem_pkg::*; (
    input  logic                 i_clock,
    input  logic                 i_rst,
    // EX/MEM fields
    input  logic                 i_mem_read,
    input  logic                 i_mem_write,
    input  access_size_t         i_size,
    input  logic                 i_branch,
    input  logic                 i_zero,
    input  logic [PC_W-1:0]      i_branch_addr,
    input  logic [DATA_W-1:0]    i_alu_result,
    input  logic [DATA_W-1:0]    i_write_data,
    input  logic [REG_W-1:0]     i_selected_reg,
    input  logic                 i_reg_write,
    input  logic                 i_mem_to_reg,
    input  logic                 i_r31_ctrl,
    input  logic                 i_hlt,
    input  logic [PC_W-1:0]      i_pc,
    // Fetch stage
    output logic                 o_branch_taken,
    output logic [PC_W-1:0]      o_branch_addr,
    // WB stage
    output logic [DATA_W-1:0]    o_mem_data,
    output logic [DATA_W-1:0]    o_alu_result,
    output logic [REG_W-1:0]     o_selected_reg,
    output logic                 o_reg_write,
    output logic                 o_mem_to_reg,
    output logic                 o_r31_ctrl,
    output logic [PC_W-1:0]      o_pc,
    output logic                 o_hlt,
    // Wishbone classic debug port
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    input  logic                 i_wb_we,
    input  logic [DM_ADDR_W-1:0] i_wb_adr,
    output logic [BYTE_W-1:0]    o_wb_dat,
    output logic                 o_wb_ack
);

    logic                 dbg_read_en;
    logic [DM_ADDR_W-1:0] dbg_address;
    logic [BYTE_W-1:0]    dbg_byte;

    mem_wb_if mem_wb_bus ();

    mem_stage u_mem_stage (
        .i_clock        (i_clock),
        .i_mem_read     (i_mem_read),
        .i_mem_write    (i_mem_write),
        .i_size         (i_size),
        .i_branch       (i_branch),
        .i_zero         (i_zero),
        .i_branch_addr  (i_branch_addr),
        .i_alu_result   (i_alu_result),
        .i_write_data   (i_write_data),
        .i_selected_reg (i_selected_reg),
        .i_reg_write    (i_reg_write),
        .i_mem_to_reg   (i_mem_to_reg),
        .i_r31_ctrl     (i_r31_ctrl),
        .i_hlt          (i_hlt),
        .i_pc           (i_pc),
        .i_dbg_read_en  (dbg_read_en),
        .i_dbg_address  (dbg_address),
        .o_dbg_byte     (dbg_byte),
        .o_branch_taken (o_branch_taken),
        .o_branch_addr  (o_branch_addr),
        .mem_wb         (mem_wb_bus.stage)
    );

    mem_wb_register u_mem_wb_register (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .mem_wb         (mem_wb_bus.wb),
        .o_mem_data     (o_mem_data),
        .o_alu_result   (o_alu_result),
        .o_selected_reg (o_selected_reg),
        .o_reg_write    (o_reg_write),
        .o_mem_to_reg   (o_mem_to_reg),
        .o_r31_ctrl     (o_r31_ctrl),
        .o_hlt          (o_hlt),
        .o_pc           (o_pc)
    );

    debug_dm_reader u_debug_dm_reader (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_wb_cyc      (i_wb_cyc),
        .i_wb_stb      (i_wb_stb),
        .i_wb_we       (i_wb_we),
        .i_wb_adr      (i_wb_adr),
        .o_wb_dat      (o_wb_dat),
        .o_wb_ack      (o_wb_ack),
        .o_dbg_read_en (dbg_read_en),
        .o_dbg_address (dbg_address),
        .i_dbg_byte    (dbg_byte)
    );

endmodule

//--- test/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

logic [BYTE_W-1:0] shadow [DM_BYTES];               // Mirror of data memory contents

// Zero-extended little-endian load aligned by access size
function automatic logic [DATA_W-1:0] aligned_load(input logic [DM_ADDR_W-1:0] addr,
                                                   input access_size_t size);
    logic [DM_ADDR_W-1:0] base;
    case (size)
        ACC_WORD: begin
            base = {addr[DM_ADDR_W-1:2], 2'b00};
            return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
        end
        ACC_HALF: begin
            base = {addr[DM_ADDR_W-1:1], 1'b0};
            return {{(DATA_W-2*BYTE_W){1'b0}}, shadow[base + 1], shadow[base]};
        end
        ACC_BYTE: return {{(DATA_W-BYTE_W){1'b0}}, shadow[addr]};
        default:  return '0;
    endcase
endfunction

function automatic void update_shadow(input logic [DM_ADDR_W-1:0] addr,
                                      input access_size_t size,
                                      input logic [DATA_W-1:0] data);
    logic [DM_ADDR_W-1:0] base;
    case (size)
        ACC_WORD: begin
            base = {addr[DM_ADDR_W-1:2], 2'b00};
            for (int i = 0; i < 4; i++) begin
                shadow[base + i] = data[i*BYTE_W +: BYTE_W];
            end
        end
        ACC_HALF: begin
            base = {addr[DM_ADDR_W-1:1], 1'b0};
            shadow[base]     = data[BYTE_W-1:0];
            shadow[base + 1] = data[2*BYTE_W-1:BYTE_W];
        end
        ACC_BYTE: shadow[addr] = data[BYTE_W-1:0];
        default: begin
        end
    endcase
endfunction

// Taken only for a branch whose compare came out equal
function automatic logic branch_select(input logic branch, input logic zero);
    case ({branch, zero})
        2'b11:   return 1'b1;
        default: return 1'b0;
    endcase
endfunction

task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
                          input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
        fail_now($sformatf("CHECK FAILED time %0t: %s expected %h, got %h",
                           $time, name, expected, actual));
    end
endtask

task automatic check_byte(input string name, input logic [BYTE_W-1:0] expected,
                          input logic [BYTE_W-1:0] actual);
    if (actual !== expected) begin
        fail_now($sformatf("CHECK FAILED time %0t: %s expected %h, got %h",
                           $time, name, expected, actual));
    end
endtask

task automatic check_reg(input string name, input logic [REG_W-1:0] expected,
                         input logic [REG_W-1:0] actual);
    if (actual !== expected) begin
        fail_now($sformatf("CHECK FAILED time %0t: %s expected %0d, got %0d",
                           $time, name, expected, actual));
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        fail_now($sformatf("CHECK FAILED time %0t: %s expected %b, got %b",
                           $time, name, expected, actual));
    end
endtask

task automatic check_pc(input string name, input logic [PC_W-1:0] expected,
                        input logic [PC_W-1:0] actual);
    if (actual !== expected) begin
        fail_now($sformatf("CHECK FAILED time %0t: %s expected %h, got %h",
                           $time, name, expected, actual));
    end
endtask

`endif

//--- test/tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem import mips_mem_pkg::*; ();

    localparam int ACK_TIMEOUT   = 16;              // Cycles allowed for a debug ack
    localparam int DRAIN_TIMEOUT = 8;

    // Expected MEM/WB register content due in a given cycle
    typedef struct packed {
        int                due;
        logic [DATA_W-1:0] mem_data;
        logic [DATA_W-1:0] alu_result;
        logic [REG_W-1:0]  selected_reg;
        logic              reg_write;
        logic              mem_to_reg;
        logic              r31_ctrl;
        logic              hlt;
        logic [PC_W-1:0]   pc;
    } wb_exp_t;

    logic                 i_clock;
    logic                 i_rst;
    logic                 i_mem_read;
    logic                 i_mem_write;
    access_size_t         i_size;
    logic                 i_branch;
    logic                 i_zero;
    logic [PC_W-1:0]      i_branch_addr;
    logic [DATA_W-1:0]    i_alu_result;
    logic [DATA_W-1:0]    i_write_data;
    logic [REG_W-1:0]     i_selected_reg;
    logic                 i_reg_write;
    logic                 i_mem_to_reg;
    logic                 i_r31_ctrl;
    logic                 i_hlt;
    logic [PC_W-1:0]      i_pc;
    logic                 i_wb_cyc;
    logic                 i_wb_stb;
    logic                 i_wb_we;
    logic [DM_ADDR_W-1:0] i_wb_adr;
    logic                 o_branch_taken;
    logic [PC_W-1:0]      o_branch_addr;
    logic [DATA_W-1:0]    o_mem_data;
    logic [DATA_W-1:0]    o_alu_result;
    logic [REG_W-1:0]     o_selected_reg;
    logic                 o_reg_write;
    logic                 o_mem_to_reg;
    logic                 o_r31_ctrl;
    logic [PC_W-1:0]      o_pc;
    logic                 o_hlt;
    logic [BYTE_W-1:0]    o_wb_dat;
    logic                 o_wb_ack;

    integer          seed;
    int              cycle      = 0;                // Counts rising edges
    int              comb_cycle = -1;               // Cycle of the instruction now in MEM
    logic            cur_branch;
    logic            cur_zero;
    logic [PC_W-1:0] cur_branch_addr;
    wb_exp_t         wb_q [$];

    mem_subsystem_top uut (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_mem_read     (i_mem_read),
        .i_mem_write    (i_mem_write),
        .i_size         (i_size),
        .i_branch       (i_branch),
        .i_zero         (i_zero),
        .i_branch_addr  (i_branch_addr),
        .i_alu_result   (i_alu_result),
        .i_write_data   (i_write_data),
        .i_selected_reg (i_selected_reg),
        .i_reg_write    (i_reg_write),
        .i_mem_to_reg   (i_mem_to_reg),
        .i_r31_ctrl     (i_r31_ctrl),
        .i_hlt          (i_hlt),
        .i_pc           (i_pc),
        .o_branch_taken (o_branch_taken),
        .o_branch_addr  (o_branch_addr),
        .o_mem_data     (o_mem_data),
        .o_alu_result   (o_alu_result),
        .o_selected_reg (o_selected_reg),
        .o_reg_write    (o_reg_write),
        .o_mem_to_reg   (o_mem_to_reg),
        .o_r31_ctrl     (o_r31_ctrl),
        .o_pc           (o_pc),
        .o_hlt          (o_hlt),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack)
    );

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    `include "tb_mem_model.svh"

    always #5 i_clock = ~i_clock;

    always @(posedge i_clock) cycle <= cycle + 1;

    // Outputs are settled at the falling edge
    always @(negedge i_clock) begin : compare_outputs
        wb_exp_t e;
        if (comb_cycle == cycle) begin
            check_bit("o_branch_taken", branch_select(cur_branch, cur_zero), o_branch_taken);
            check_pc("o_branch_addr", cur_branch_addr, o_branch_addr);
        end
        if (wb_q.size() != 0) begin
            e = wb_q[0];
            if (e.due == cycle) begin
                void'(wb_q.pop_front());
                check_data("o_mem_data", e.mem_data, o_mem_data);
                check_data("o_alu_result", e.alu_result, o_alu_result);
                check_reg("o_selected_reg", e.selected_reg, o_selected_reg);
                check_bit("o_reg_write", e.reg_write, o_reg_write);
                check_bit("o_mem_to_reg", e.mem_to_reg, o_mem_to_reg);
                check_bit("o_r31_ctrl", e.r31_ctrl, o_r31_ctrl);
                check_bit("o_hlt", e.hlt, o_hlt);
                check_pc("o_pc", e.pc, o_pc);
            end
        end
    end

    function automatic access_size_t pick_size();
        logic [31:0] r;
        r = $random(seed);
        return access_size_t'(r % 3);
    endfunction

    // Random upper bits since the memory only sees the low address bits
    function automatic logic [DATA_W-1:0] rand_alu(input logic [DM_ADDR_W-1:0] addr);
        logic [DATA_W-1:0] r;
        r = $random(seed);
        return {r[DATA_W-1:DM_ADDR_W], addr};
    endfunction

    task automatic issue_op(input logic rd, input logic wr, input access_size_t sz,
                            input logic [DATA_W-1:0] alu, input logic [DATA_W-1:0] wdata,
                            input logic br, input logic zr);
        wb_exp_t e;
        @(posedge i_clock);
        #1;
        i_mem_read     = rd;
        i_mem_write    = wr;
        i_size         = sz;
        i_alu_result   = alu;
        i_write_data   = wdata;
        i_branch       = br;
        i_zero         = zr;
        i_branch_addr  = $random(seed);
        i_selected_reg = $random(seed);
        i_reg_write    = $random(seed);
        i_mem_to_reg   = $random(seed);
        i_r31_ctrl     = $random(seed);
        i_hlt          = $random(seed);
        i_pc           = $random(seed);
        cur_branch      = br;
        cur_zero        = zr;
        cur_branch_addr = i_branch_addr;
        comb_cycle      = cycle;
        e.due          = cycle + 1;
        e.mem_data     = rd ? aligned_load(alu[DM_ADDR_W-1:0], sz) : '0;   // Before this store
        e.alu_result   = alu;
        e.selected_reg = i_selected_reg;
        e.reg_write    = i_reg_write;
        e.mem_to_reg   = i_mem_to_reg;
        e.r31_ctrl     = i_r31_ctrl;
        e.hlt          = i_hlt;
        e.pc           = i_pc;
        wb_q.push_back(e);
        if (wr) begin
            update_shadow(alu[DM_ADDR_W-1:0], sz, wdata);
        end
    endtask

    task automatic store(input logic [DM_ADDR_W-1:0] addr, input access_size_t sz,
                         input logic [DATA_W-1:0] data);
        issue_op(1'b0, 1'b1, sz, rand_alu(addr), data, 1'b0, 1'b0);
    endtask

    task automatic load(input logic [DM_ADDR_W-1:0] addr, input access_size_t sz);
        issue_op(1'b1, 1'b0, sz, rand_alu(addr), $random(seed), 1'b0, 1'b0);
    endtask

    task automatic nop_op();
        issue_op(1'b0, 1'b0, ACC_WORD, $random(seed), $random(seed), 1'b0, 1'b0);
    endtask

    // One Wishbone classic master access
    task automatic wb_access(input logic we, input logic [DM_ADDR_W-1:0] addr);
        logic [BYTE_W-1:0] expected;
        int                start;
        int                waited;
        @(posedge i_clock);
        #1;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = addr;
        expected = shadow[addr];
        start    = cycle;
        waited   = 0;
        while (!o_wb_ack && waited < ACK_TIMEOUT) begin
            @(negedge i_clock);
            waited++;
        end
        if (!o_wb_ack) begin
            fail_now("Timeout: the debug acknowledge never came");
        end
        if (cycle - start != 1) begin
            fail_now($sformatf("Debug acknowledge took %0d cycles instead of 1", cycle - start));
        end
        if (!we) begin
            check_byte("o_wb_dat", expected, o_wb_dat);
        end
        @(posedge i_clock);
        #1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        check_bit("o_wb_ack", 1'b0, o_wb_ack);      // Ack lasts a single cycle
    endtask

    // Waits until every issued instruction has been compared
    task automatic drain();
        int waited;
        waited = 0;
        while (wb_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge i_clock);
            waited++;
        end
        if (wb_q.size() != 0) begin
            fail_now("Timeout: write-back results were never compared");
        end
    endtask

    initial begin
        logic [DM_ADDR_W-1:0] addr;
        seed           = 32'hc8d25508;
        i_clock        = 1'b0;
        i_rst          = 1'b1;
        i_mem_read     = 1'b0;
        i_mem_write    = 1'b0;
        i_size         = ACC_WORD;
        i_branch       = 1'b0;
        i_zero         = 1'b0;
        i_branch_addr  = '0;
        i_alu_result   = '0;
        i_write_data   = '0;
        i_selected_reg = '0;
        i_reg_write    = 1'b0;
        i_mem_to_reg   = 1'b0;
        i_r31_ctrl     = 1'b0;
        i_hlt          = 1'b0;
        i_pc           = '0;
        i_wb_cyc       = 1'b0;
        i_wb_stb       = 1'b0;
        i_wb_we        = 1'b0;
        i_wb_adr       = '0;
        repeat (8) @(posedge i_clock);
        #1;
        i_rst = 1'b0;
        check_bit("o_reg_write", 1'b0, o_reg_write);
        check_bit("o_mem_to_reg", 1'b0, o_mem_to_reg);
        check_bit("o_hlt", 1'b0, o_hlt);
        check_bit("o_wb_ack", 1'b0, o_wb_ack);

        // Give every byte a known value since memory is not reset
        for (int i = 0; i < DM_BYTES; i += 4) begin
            store(DM_ADDR_W'(i), ACC_WORD, $random(seed));
        end
        repeat (24) begin
            store($random(seed), pick_size(), $random(seed));
            load($random(seed), ACC_WORD);
            load($random(seed), ACC_HALF);
            load($random(seed), ACC_BYTE);
        end

        // Load right behind a store to the same place
        for (int s = 0; s < 3; s++) begin
            addr = $random(seed);
            store(addr, access_size_t'(s), $random(seed));
            load(addr, access_size_t'(s));
            load(addr, ACC_WORD);
        end

        // All four branch/zero combinations with zero mem_data for non-loads
        for (int c = 0; c < 4; c++) begin
            issue_op(1'b0, 1'b0, ACC_WORD, $random(seed), $random(seed), c[1], c[0]);
        end
        nop_op();
        drain();

        repeat (12) wb_access(1'b0, $random(seed));
        addr = $random(seed);
        wb_access(1'b1, addr);                      // Acked and memory untouched
        wb_access(1'b0, addr);
        load(addr, ACC_BYTE);
        nop_op();
        drain();

        // Debug in the low half and pipeline loads in the high half
        fork
            repeat (10) wb_access(1'b0, {1'b0, 6'($random(seed))});
            repeat (30) load({1'b1, 6'($random(seed))}, pick_size());
        join
        nop_op();
        drain();

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- all.f
hw/mips_mem_pkg.sv
hw/mem_wb_if.sv
hw/data_memory.sv
hw/mem_stage.sv
hw/mem_wb_register.sv
hw/debug_dm_reader.sv
hw/mem_subsystem_top.sv
+incdir+test
test/tb_mem_subsystem.sv
